// File: flist.f
+incdir+tests
src/exec_pkg.sv
src/alu.sv
src/int_muldiv.sv
src/branch_cond.sv
src/execute.sv
src/exec_top.sv
tests/tb_exec_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_exec_top -o tb_exec_top
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi
./obj_dir/tb_exec_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "^No errors$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import exec_pkg::*;
  (
  input  word_t    a_i,
  input  word_t    b_i,
  input  alufunc_e func_i,
  output word_t    y_o,
  output logic     c_o,
  output logic     z_o,
  output logic     n_o,
  output logic     v_o
  );

  logic [32:0] sum;
  logic [32:0] diff;

  assign sum  = {1'b0, a_i} + {1'b0, b_i};
  assign diff = {1'b0, a_i} - {1'b0, b_i};  // bit 32 is the borrow

  always_comb
  begin
    y_o = sum[31:0];
    c_o = 1'b0;
    v_o = 1'b0;
    case (func_i)
      ALU_AND: y_o = a_i & b_i;
      ALU_OR:  y_o = a_i | b_i;
      ALU_ADD:
      begin
        y_o = sum[31:0];
        c_o = sum[32];
        v_o = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
      end
      ALU_SUB:
      begin
        y_o = diff[31:0];
        c_o = diff[32];
        v_o = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
      end
      ALU_LSL: y_o = a_i << b_i[4:0];
      ALU_ASR: y_o = $signed(a_i) >>> b_i[4:0];
      ALU_LSR: y_o = a_i >> b_i[4:0];
      ALU_XOR: y_o = a_i ^ b_i;
      default: y_o = sum[31:0];
    endcase
  end

  assign z_o = (y_o == 32'h0);
  assign n_o = y_o[31];

endmodule

`default_nettype wire

// File: src/branch_cond.sv
`timescale 1ns/100ps
`default_nettype none

module branch_cond import exec_pkg::*;
  (
  input  brcond_e cond_i,
  input  ccr_t    ccr_i,
  output logic    taken_o
  );

  logic ltu;
  logic lt;
  logic eq;

  assign ltu = ccr_i[2];
  assign lt  = ccr_i[1];
  assign eq  = ccr_i[0];

  always_comb
  begin
    case (cond_i)
      BR_ALWAYS: taken_o = 1'b1;
      BR_EQ:     taken_o = eq;
      BR_NE:     taken_o = !eq;
      BR_GTU:    taken_o = !(ltu || eq);
      BR_GT:     taken_o = !(lt || eq);
      BR_GE:     taken_o = !lt;
      BR_LE:     taken_o = lt || eq;
      BR_LT:     taken_o = lt;
      BR_GEU:    taken_o = !ltu;
      BR_LTU:    taken_o = ltu;
      BR_LEU:    taken_o = ltu || eq;
      default:   taken_o = 1'b0;  // unused encodings never branch
    endcase
  end

endmodule

`default_nettype wire

// File: src/exec_pkg.sv
`default_nettype none

package exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] instr_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [2:0]  ccr_t;  // {ltu, lt, eq}

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_PUSH   = 4'h1,
    T_POP    = 4'h2,
    T_CMP    = 4'h3,
    T_MOV    = 4'h4,
    T_INTU   = 4'h5,
    T_INT    = 4'h6,
    T_ALU    = 4'h7,
    T_BRANCH = 4'h8,
    T_JUMP   = 4'h9,
    T_LOAD   = 4'ha,
    T_STORE  = 4'hb,
    T_LDI    = 4'hc
  } itype_e;

  typedef enum logic [2:0] {
    ALU_AND = 3'h0,
    ALU_OR  = 3'h1,
    ALU_ADD = 3'h2,
    ALU_SUB = 3'h3,
    ALU_LSL = 3'h4,
    ALU_ASR = 3'h5,
    ALU_LSR = 3'h6,
    ALU_XOR = 3'h7
  } alufunc_e;

  typedef enum logic [1:0] {
    INT_MUL  = 2'h0,
    INT_DIV  = 2'h1,
    INT_MOD  = 2'h2,
    INT_DIVU = 2'h3
  } intfunc_e;

  typedef enum logic [3:0] {
    BR_ALWAYS = 4'h0,
    BR_EQ     = 4'h1,
    BR_NE     = 4'h2,
    BR_GTU    = 4'h3,
    BR_GT     = 4'h4,
    BR_GE     = 4'h5,
    BR_LE     = 4'h6,
    BR_LT     = 4'h7,
    BR_GEU    = 4'h8,
    BR_LTU    = 4'h9,
    BR_LEU    = 4'ha
  } brcond_e;

  typedef enum logic [1:0] {
    ST_RUN    = 2'h0,
    ST_MULDIV = 2'h1,
    ST_HALT   = 2'h2
  } exec_state_e;

endpackage

`default_nettype wire

// File: src/exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_top import exec_pkg::*;
  #(
  parameter word_t VECT_BASE     = 32'hffffffc0,
  parameter int    MULDIV_CYCLES = 4
  )
  (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  instr_t   instr_i,
  input  word_t    pc_i,
  input  word_t    rs1_data_i,
  input  word_t    rs2_data_i,
  input  logic [2:0] irq_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output word_t    result_o,
  output word_t    pc_target_o,
  output reg_idx_t dest_o,
  output logic     reg_write_o,
  output logic     pc_set_o,
  output ccr_t     ccr_o,
  output logic     int_enabled_o,
  output logic     halt_o
  );

  execute #(
    .VECT_BASE    (VECT_BASE),
    .MULDIV_CYCLES(MULDIV_CYCLES)
  ) exec0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .irq_i        (irq_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .result_o     (result_o),
    .pc_target_o  (pc_target_o),
    .dest_o       (dest_o),
    .reg_write_o  (reg_write_o),
    .pc_set_o     (pc_set_o),
    .ccr_o        (ccr_o),
    .int_enabled_o(int_enabled_o),
    .halt_o       (halt_o)
  );

endmodule

`default_nettype wire

// File: src/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute import exec_pkg::*;
  #(
  parameter word_t VECT_BASE     = 32'hffffffc0,
  parameter int    MULDIV_CYCLES = 4
  )
  (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  instr_t   instr_i,
  input  word_t    pc_i,
  input  word_t    rs1_data_i,
  input  word_t    rs2_data_i,
  input  logic [2:0] irq_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output word_t    result_o,
  output word_t    pc_target_o,
  output reg_idx_t dest_o,
  output logic     reg_write_o,
  output logic     pc_set_o,
  output ccr_t     ccr_o,
  output logic     int_enabled_o,
  output logic     halt_o
  );

  word_t    ir_ext;
  itype_e   ir_type;
  logic [3:0] ir_op;
  reg_idx_t ir_dest;
  word_t    ir_sval;
  word_t    ir_uval;
  logic     ir_size;

  exec_state_e state;
  logic     accept;
  logic     irq_take;
  logic     single_load;

  word_t    alu_a;
  word_t    alu_b;
  alufunc_e alu_func;
  word_t    alu_y;
  logic     alu_c, alu_z, alu_n, alu_v;
  logic     br_taken;

  logic     muldiv_start;
  logic     muldiv_done;
  intfunc_e muldiv_func;
  word_t    muldiv_b;
  word_t    muldiv_result;
  reg_idx_t md_dest;

  word_t    nx_result;
  word_t    nx_target;
  logic     nx_pc_set;
  logic     nx_reg_write;
  ccr_t     nx_ccr;
  logic     nx_int_en;
  logic     nx_halt;

  assign ir_ext  = instr_i[63:32];
  assign ir_type = itype_e'(instr_i[31:28]);
  assign ir_op   = instr_i[27:24];
  assign ir_dest = instr_i[23:20];
  assign ir_sval = {{17{instr_i[15]}}, instr_i[15:1]};
  assign ir_uval = {17'h0, instr_i[15:1]};
  assign ir_size = instr_i[0];

  assign in_ready_o   = (state == ST_RUN) && (!out_valid_o || out_ready_i);
  assign accept       = in_valid_i && in_ready_o;
  assign irq_take     = (irq_i != 3'h0) && int_enabled_o;
  assign muldiv_start = accept && !irq_take && (ir_type == T_INT || ir_type == T_INTU);
  assign single_load  = accept && !muldiv_start;
  assign halt_o       = (state == ST_HALT);

  // unsigned type turns the signed divide into divu
  assign muldiv_func = (ir_type == T_INTU && ir_op[1:0] == INT_DIV) ? INT_DIVU
                                                                      : intfunc_e'(ir_op[1:0]);
  assign muldiv_b    = ir_op[3] ? ir_sval : rs2_data_i;

  always_comb
  begin
    alu_a    = rs1_data_i;
    alu_b    = rs2_data_i;
    alu_func = alufunc_e'(ir_op[2:0]);
    case (ir_type)
      T_CMP: alu_func = ALU_SUB;
      T_ALU: if (ir_op[3]) alu_b = ir_sval;
      T_PUSH:
        if (ir_op == 4'h2)  // bsr
        begin
          alu_func = ALU_ADD;
          alu_a    = {ir_sval[29:0], 2'b00};
          alu_b    = pc_i;
        end
      T_BRANCH:
      begin
        alu_func = ALU_ADD;
        alu_a    = {ir_sval[29:0], 2'b00};
        alu_b    = pc_i;
      end
      T_LOAD, T_STORE, T_JUMP:
      begin
        alu_func = ALU_ADD;
        if (!ir_size) alu_a = ir_sval;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    nx_result    = alu_y;
    nx_target    = alu_y;
    nx_pc_set    = 1'b0;
    nx_reg_write = 1'b0;
    nx_ccr       = ccr_o;
    nx_int_en    = int_enabled_o;
    nx_halt      = 1'b0;
    if (irq_take)
    begin
      nx_pc_set = 1'b1;
      nx_target = VECT_BASE + {26'h0, irq_i, 3'h0};
      nx_result = pc_i;  // return address
      nx_int_en = 1'b0;
    end
    else
      case (ir_type)
        T_ALU: nx_reg_write = 1'b1;
        T_CMP: nx_ccr = {alu_c, alu_n ^ alu_v, alu_z};
        T_LDI:
        begin
          nx_result    = ir_size ? ir_ext : ir_uval;
          nx_reg_write = 1'b1;
        end
        T_LOAD:
        begin
          nx_result    = ir_size ? ir_ext : alu_y;
          nx_reg_write = 1'b1;
        end
        T_STORE: nx_result = ir_size ? ir_ext : alu_y;
        T_MOV:
        begin
          nx_result    = (ir_op == 4'h0) ? {29'h0, ccr_o} : rs1_data_i;
          nx_reg_write = 1'b1;
        end
        T_BRANCH: nx_pc_set = br_taken;
        T_JUMP:
        begin
          nx_pc_set = 1'b1;
          nx_target = ir_size ? ir_ext : alu_y;
        end
        T_PUSH:
          if (ir_op == 4'h2)
          begin
            nx_pc_set = 1'b1;
            nx_result = pc_i;
          end
        T_INH:
          case (ir_op)
            4'h2: nx_int_en = 1'b0;  // cli
            4'h3: nx_int_en = 1'b1;  // sti
            4'h4: nx_halt = 1'b1;
            default: ;
          endcase
        default: ;
      endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state         <= ST_RUN;
      out_valid_o   <= 1'b0;
      reg_write_o   <= 1'b0;
      pc_set_o      <= 1'b0;
      ccr_o         <= '0;
      int_enabled_o <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        ccr_o         <= nx_ccr;
        int_enabled_o <= nx_int_en;
      end
      case (state)
        ST_RUN:
          if (muldiv_start)
            state <= ST_MULDIV;
          else if (single_load && nx_halt)
            state <= ST_HALT;
        ST_MULDIV: if (muldiv_done) state <= ST_RUN;
        default: ;  // halt holds until reset
      endcase
      if (single_load || muldiv_done)
        out_valid_o <= 1'b1;
      else if (out_ready_i)
        out_valid_o <= 1'b0;
      if (single_load)
      begin
        reg_write_o <= nx_reg_write;
        pc_set_o    <= nx_pc_set;
      end
      else if (muldiv_done)
      begin
        reg_write_o <= 1'b1;
        pc_set_o    <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (muldiv_start)
      md_dest <= ir_dest;
    if (single_load)
    begin
      result_o    <= nx_result;
      dest_o      <= ir_dest;
      pc_target_o <= nx_target;
    end
    else if (muldiv_done)
    begin
      result_o <= muldiv_result;
      dest_o   <= md_dest;
    end
  end

  alu alu0 (
    .a_i   (alu_a),
    .b_i   (alu_b),
    .func_i(alu_func),
    .y_o   (alu_y),
    .c_o   (alu_c),
    .z_o   (alu_z),
    .n_o   (alu_n),
    .v_o   (alu_v)
  );

  int_muldiv #(.MULDIV_CYCLES(MULDIV_CYCLES)) muldiv0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (muldiv_start),
    .func_i  (muldiv_func),
    .a_i     (rs1_data_i),
    .b_i     (muldiv_b),
    .done_o  (muldiv_done),
    .result_o(muldiv_result)
  );

  branch_cond br0 (
    .cond_i (brcond_e'(ir_op)),
    .ccr_i  (ccr_o),
    .taken_o(br_taken)
  );

  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable({result_o, pc_target_o, dest_o, reg_write_o, pc_set_o}));

  // no new instruction while the multiply/divide unit is counting
  a_muldiv_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
    muldiv_start |=> (!in_ready_o)[*MULDIV_CYCLES]);

endmodule

`default_nettype wire

// File: src/int_muldiv.sv
`timescale 1ns/100ps
`default_nettype none

module int_muldiv import exec_pkg::*;
  #(
  parameter int MULDIV_CYCLES = 4
  )
  (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     start_i,
  input  intfunc_e func_i,
  input  word_t    a_i,
  input  word_t    b_i,
  output logic     done_o,
  output word_t    result_o
  );

  localparam int CW = (MULDIV_CYCLES > 1) ? $clog2(MULDIV_CYCLES) : 1;

  logic          busy;
  logic [CW-1:0] cnt;
  intfunc_e      func_q;
  word_t         a_q;
  word_t         b_q;
  logic          div_zero;
  logic          div_ovf;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (start_i)
    begin
      busy <= 1'b1;
      cnt  <= CW'(MULDIV_CYCLES - 1);
    end
    else if (busy)
    begin
      if (cnt == '0)
        busy <= 1'b0;
      else
        cnt <= cnt - CW'(1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      func_q <= func_i;
      a_q    <= a_i;
      b_q    <= b_i;
    end
  end

  // result settles over the count and is sampled only with done_o
  assign div_zero = (b_q == 32'h0);
  assign div_ovf  = (a_q == 32'h8000_0000) && (b_q == 32'hffff_ffff);

  always_comb
  begin
    case (func_q)
      INT_MUL:  result_o = a_q * b_q;
      INT_DIV:  result_o = div_zero ? 32'hffff_ffff :
                           div_ovf ? a_q : word_t'($signed(a_q) / $signed(b_q));
      INT_MOD:  result_o = div_zero ? a_q :
                           div_ovf ? 32'h0 : word_t'($signed(a_q) % $signed(b_q));
      INT_DIVU: result_o = div_zero ? 32'hffff_ffff : a_q / b_q;
      default:  result_o = 32'h0;
    endcase
  end

  assign done_o = busy && (cnt == '0);

  a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> !busy);

endmodule

`default_nettype wire

// File: tests/tb_exec_model.svh
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

typedef struct packed {
  word_t    result;
  word_t    target;
  reg_idx_t dest;
  logic     reg_write;
  logic     pc_set;
  logic     chk_result;
  ccr_t     ccr;
  logic     int_en;
  logic     halt;
  logic     is_muldiv;
} exp_t;

// architectural state seen by the model
ccr_t model_ccr;
logic model_int_en;
logic model_halt;

function automatic instr_t make_instr(logic [3:0] itype, logic [3:0] op, reg_idx_t dest,
                                      logic [14:0] imm, logic size, word_t ext);
  return {ext, itype, op, dest, 4'h0, imm, size};
endfunction

function automatic exp_t predict_exec(instr_t ins, word_t pc, word_t a, word_t b,
                                      logic [2:0] irq);
  exp_t       e;
  word_t      sval;
  word_t      opb;
  logic [1:0] fn;
  logic       ltu;
  logic       lt;
  logic       eq;
  e      = '0;
  sval   = {{17{ins[15]}}, ins[15:1]};
  opb    = ins[27] ? sval : b;  // op bit 3 picks the immediate
  fn     = ins[25:24];
  ltu    = model_ccr[2];
  lt     = model_ccr[1];
  eq     = model_ccr[0];
  e.dest = ins[23:20];
  if (irq != 3'h0 && model_int_en)
  begin
    e.pc_set     = 1'b1;
    e.target     = VECT_BASE + word_t'(irq) * 32'd8;
    e.result     = pc;  // return address
    e.chk_result = 1'b1;
    model_int_en = 1'b0;
  end
  else
    case (ins[31:28])
      T_ALU:
      begin
        e.reg_write = 1'b1;
        case (ins[26:24])
          ALU_AND: e.result = a & opb;
          ALU_OR:  e.result = a | opb;
          ALU_ADD: e.result = a + opb;
          ALU_SUB: e.result = a - opb;
          ALU_LSL: e.result = a << opb[4:0];
          ALU_ASR: e.result = word_t'($signed(a) >>> opb[4:0]);
          ALU_LSR: e.result = a >> opb[4:0];
          ALU_XOR: e.result = a ^ opb;
        endcase
      end
      T_CMP: model_ccr = {a < b, $signed(a) < $signed(b), a == b};
      T_LDI:
      begin
        e.reg_write = 1'b1;
        e.result    = ins[0] ? ins[63:32] : {17'h0, ins[15:1]};
      end
      T_LOAD:
      begin
        e.reg_write = 1'b1;
        e.result    = ins[0] ? ins[63:32] : sval + b;
      end
      T_STORE:
      begin
        e.chk_result = 1'b1;  // store address
        e.result     = ins[0] ? ins[63:32] : sval + b;
      end
      T_MOV:
      begin
        e.reg_write = 1'b1;
        e.result    = (ins[27:24] == 4'h0) ? {29'h0, model_ccr} : a;
      end
      T_BRANCH:
      begin
        e.target = {sval[29:0], 2'b00} + pc;
        case (ins[27:24])
          BR_ALWAYS: e.pc_set = 1'b1;
          BR_EQ:     e.pc_set = eq;
          BR_NE:     e.pc_set = !eq;
          BR_GTU:    e.pc_set = !ltu && !eq;
          BR_GT:     e.pc_set = !lt && !eq;
          BR_GE:     e.pc_set = !lt;
          BR_LE:     e.pc_set = lt || eq;
          BR_LT:     e.pc_set = lt;
          BR_GEU:    e.pc_set = !ltu;
          BR_LTU:    e.pc_set = ltu;
          BR_LEU:    e.pc_set = ltu || eq;
          default:   e.pc_set = 1'b0;
        endcase
      end
      T_JUMP:
      begin
        e.pc_set = 1'b1;
        e.target = ins[0] ? ins[63:32] : sval + b;
      end
      T_INT, T_INTU:
      begin
        e.reg_write = 1'b1;
        e.is_muldiv = 1'b1;
        if (ins[31:28] == T_INTU && fn == 2'h1)
          fn = 2'h3;  // unsigned divide
        case (fn)
          INT_MUL:  e.result = a * opb;
          INT_DIV:
            if (opb == 32'h0)
              e.result = '1;
            else if (a == 32'h8000_0000 && opb == '1)
              e.result = a;  // wraps
            else
              e.result = word_t'($signed(a) / $signed(opb));
          INT_MOD:
            if (opb == 32'h0)
              e.result = a;
            else if (a == 32'h8000_0000 && opb == '1)
              e.result = 32'h0;
            else
              e.result = word_t'($signed(a) % $signed(opb));
          INT_DIVU: e.result = (opb == 32'h0) ? '1 : a / opb;
        endcase
      end
      T_INH:
        case (ins[27:24])
          4'h2: model_int_en = 1'b0;
          4'h3: model_int_en = 1'b1;
          4'h4: model_halt = 1'b1;
          default: ;
        endcase
      default: ;
    endcase
  e.chk_result = e.chk_result || e.reg_write;
  e.ccr        = model_ccr;
  e.int_en     = model_int_en;
  e.halt       = model_halt;
  return e;
endfunction

`endif

// File: tests/tb_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exec_top import exec_pkg::*;
  ();

  localparam word_t VECT_BASE     = 32'hffffffc0;
  localparam int    MULDIV_CYCLES = 4;
  localparam int    N_INSTR       = 220;
  localparam int    WATCH_NS      = N_INSTR * (MULDIV_CYCLES + 2) * 40 * 4;

  logic       clk_i;
  logic       rst_i;
  logic       in_valid_i;
  logic       in_ready_o;
  instr_t     instr_i;
  word_t      pc_i;
  word_t      rs1_data_i;
  word_t      rs2_data_i;
  logic [2:0] irq_i;
  logic       out_valid_o;
  logic       out_ready_i;
  word_t      result_o;
  word_t      pc_target_o;
  reg_idx_t   dest_o;
  logic       reg_write_o;
  logic       pc_set_o;
  ccr_t       ccr_o;
  logic       int_enabled_o;
  logic       halt_o;

  `include "tb_exec_model.svh"

  logic [31:0] lfsr;
  logic [1:0]  ready_level;  // out_ready_i high when 2 random bits reach this
  int          cycle;
  int          last_md_accept;
  logic        last_md;
  word_t       cur_pc;
  exp_t        exp_q[$];
  logic        held;
  word_t       held_result;
  word_t       held_target;
  reg_idx_t    held_dest;
  logic        held_rw;
  logic        held_ps;

  exec_top #(.VECT_BASE(VECT_BASE), .MULDIV_CYCLES(MULDIV_CYCLES)) uut (.*);

  always #20 clk_i = ~clk_i;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t act, word_t exp);
    if (act !== exp)
      stop_with_error($sformatf("ERROR %0d ns: %s is %h, expected %h", $time, name, act, exp));
  endtask

  task automatic check_idx(string name, reg_idx_t act, reg_idx_t exp);
    if (act !== exp)
      stop_with_error($sformatf("ERROR %0d ns: %s is %h, expected %h", $time, name, act, exp));
  endtask

  task automatic check_ccr(string name, ccr_t act, ccr_t exp);
    if (act !== exp)
      stop_with_error($sformatf("ERROR %0d ns: %s is %b, expected %b", $time, name, act, exp));
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp)
      stop_with_error($sformatf("ERROR %0d ns: %s is %b, expected %b", $time, name, act, exp));
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    cycle++;
    out_ready_i = (2'(rand_bits(2)) >= ready_level);
  endtask

  task automatic send(instr_t ins, word_t a, word_t b, logic [2:0] irq);
    exp_t e;
    logic done;
    while (rand_bits(2) == 0)
      next_cycle();  // input bubble
    in_valid_i = 1'b1;
    instr_i    = ins;
    pc_i       = cur_pc;
    rs1_data_i = a;
    rs2_data_i = b;
    irq_i      = irq;
    done       = 1'b0;
    while (!done)
    begin
      #5;
      if (in_ready_o)
      begin
        if (last_md && (cycle - last_md_accept < MULDIV_CYCLES + 1))
          stop_with_error("an instruction was accepted while multiply/divide was busy");
        e              = predict_exec(ins, cur_pc, a, b, irq);
        exp_q.push_back(e);
        last_md        = e.is_muldiv;
        last_md_accept = cycle;
        done           = 1'b1;
      end
      next_cycle();
    end
    in_valid_i = 1'b0;
    irq_i      = 3'h0;
    cur_pc     = cur_pc + 32'd8;
  endtask

  // mix 0 alu/ldi/load/store/mov/jump, 1 multiply/divide, 2 both
  task automatic send_random(int mix, logic [2:0] irq);
    logic [3:0] itype;
    logic [2:0] pick;
    word_t      f;
    word_t      a;
    word_t      b;
    word_t      ext;
    pick = 3'(rand_bits(3));
    if (mix == 1 || (mix == 2 && pick < 3'h2))
      itype = rand_bits(1) ? T_INTU : T_INT;
    else
      case (pick)
        3'h3: itype = T_LDI;
        3'h4: itype = T_LOAD;
        3'h5: itype = T_STORE;
        3'h6: itype = T_MOV;
        3'h7: itype = T_JUMP;
        default: itype = T_ALU;
      endcase
    f   = rand_bits(24);  // op, dest, imm, size
    a   = rand_bits(32);
    b   = (rand_bits(3) == 0) ? 32'h0 : rand_bits(32);
    ext = rand_bits(32);
    send(make_instr(itype, f[23:20], f[19:16], f[15:1], f[0], ext), a, b, irq);
  endtask

  task automatic send_cmp_branch(int cond);
    word_t a;
    word_t b;
    word_t imm;
    a   = rand_bits(32);
    b   = (rand_bits(2) == 0) ? a : rand_bits(32);
    imm = rand_bits(15);
    send(make_instr(T_CMP, 4'h0, 4'h0, 15'h0, 1'b0, 32'h0), a, b, 3'h0);
    send(make_instr(T_BRANCH, 4'(cond), 4'h0, imm[14:0], 1'b0, 32'h0), 32'h0, 32'h0, 3'h0);
  endtask

  task automatic send_inh(logic [3:0] op);
    send(make_instr(T_INH, op, 4'h0, 15'h0, 1'b0, 32'h0), 32'h0, 32'h0, 3'h0);
  endtask

  always @(negedge clk_i)
  begin : compare_outputs
    exp_t e;
    #10;
    if (!rst_i)
    begin
      if (held)
      begin
        check_bit("out_valid_o", out_valid_o, 1'b1);
        check_word("result_o", result_o, held_result);
        check_word("pc_target_o", pc_target_o, held_target);
        check_idx("dest_o", dest_o, held_dest);
        check_bit("reg_write_o", reg_write_o, held_rw);
        check_bit("pc_set_o", pc_set_o, held_ps);
      end
      if (out_valid_o && out_ready_i)
      begin
        if (exp_q.size() == 0)
          stop_with_error("a result left the stage with no instruction outstanding");
        e = exp_q.pop_front();
        check_bit("reg_write_o", reg_write_o, e.reg_write);
        check_bit("pc_set_o", pc_set_o, e.pc_set);
        if (e.chk_result)
          check_word("result_o", result_o, e.result);
        if (e.reg_write)
          check_idx("dest_o", dest_o, e.dest);
        if (e.pc_set)
          check_word("pc_target_o", pc_target_o, e.target);
        check_ccr("ccr_o", ccr_o, e.ccr);
        check_bit("int_enabled_o", int_enabled_o, e.int_en);
        check_bit("halt_o", halt_o, e.halt);
      end
      held        = out_valid_o && !out_ready_i;
      held_result = result_o;
      held_target = pc_target_o;
      held_dest   = dest_o;
      held_rw     = reg_write_o;
      held_ps     = pc_set_o;
    end
  end

  initial
  begin
    #(WATCH_NS);
    stop_with_error("timeout: the stage stopped moving before the test ended");
  end

  initial
  begin
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    in_valid_i     = 1'b0;
    instr_i        = '0;
    pc_i           = '0;
    rs1_data_i     = '0;
    rs2_data_i     = '0;
    irq_i          = 3'h0;
    out_ready_i    = 1'b0;
    lfsr           = 32'h93f4_c633;
    ready_level    = 2'd1;
    cycle          = 0;
    last_md        = 1'b0;
    last_md_accept = 0;
    cur_pc         = 32'h0000_1000;
    model_ccr      = '0;
    model_int_en   = 1'b0;
    model_halt     = 1'b0;
    held           = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("halt_o", halt_o, 1'b0);
    check_bit("int_enabled_o", int_enabled_o, 1'b0);
    check_ccr("ccr_o", ccr_o, 3'b000);
    rst_i = 1'b0;

    repeat (60) send_random(0, 3'h0);
    for (int r = 0; r < 3; r++)
      for (int c = 0; c <= 10; c++)
        send_cmp_branch(c);
    repeat (24) send_random(1, 3'h0);
    ready_level = 2'd3;  // mostly stalled
    repeat (40) send_random(2, 3'h0);
    ready_level = 2'd1;

    for (int k = 1; k < 8; k++)
    begin
      send_inh(4'h3);
      send_random(0, 3'(k));  // taken
      send_random(0, 3'(k));  // enable already cleared by the entry
    end
    send_inh(4'h3);
    send_inh(4'h2);
    send_random(0, 3'h5);

    send_inh(4'h4);
    while (exp_q.size() != 0)
      next_cycle();
    in_valid_i = 1'b1;
    instr_i    = make_instr(T_ALU, 4'h2, 4'h1, 15'h0, 1'b0, 32'h0);
    repeat (8)
    begin
      next_cycle();
      #5;
      check_bit("halt_o", halt_o, 1'b1);
      check_bit("in_ready_o", in_ready_o, 1'b0);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
